// ==== vlog.f ====
logic/axi_pkg.sv
logic/read_align.sv
logic/axi_read_master.sv
logic/mem_read_slave.sv
logic/slave_cfg_regs.sv
logic/axi_read_top.sv
tb/axi_read_props.sv
tb/tb_axi_read.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_axi_read -f vlog.f -o Vtb_axi_read

run: compile
	./obj_dir/Vtb_axi_read +verilator+error+limit+1000 | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/tb_axi_read.sv ====
`timescale 1ns/1ps

module tb_axi_read import axi_pkg::*; ();

	localparam int N_RAND         = 200;
	localparam int RAND_WAIT      = 1;
	localparam int DIRECTED_BEATS = 15 + 136 + 8 * 4 + 8; // Singles, bursts, wait sweep, boundary
	localparam int DIRECTED_WAITS = 4 * 7; // 0+1+..+7 per sweep read

	logic                  clk = 1'b0;
	logic                  reset_n;
	logic                  cpu_ar_valid_i;
	logic [AXI_ID_W-1:0]   cpu_id_i;
	logic [AXI_ADDR_W-1:0] cpu_addr_i;
	logic [AXI_LEN_W-1:0]  cpu_len_i;
	acc_size_e             cpu_size_i;
	logic                  cpu_ar_ready_o;
	logic                  cpu_r_valid_o;
	logic [AXI_DATA_W-1:0] cpu_r_data_o;
	axi_resp_e             cpu_r_resp_o;
	logic [AXI_ID_W-1:0]   cpu_r_id_o;
	logic                  cpu_r_last_o;
	logic                  cfg_we_i;
	cfg_reg_e              cfg_sel_i;
	logic [CFG_DATA_W-1:0] cfg_wdata_i;
	logic                  mem_we_i;
	logic [MEM_IDX_W-1:0]  mem_idx_i;
	logic [AXI_DATA_W-1:0] mem_wdata_i;

	logic [AXI_DATA_W-1:0] mem_model [MEM_WORDS];
	logic [CFG_DATA_W-1:0] err_base_m;

	// Expected beats in arrival order
	string                 exp_name_q [$];
	logic [AXI_DATA_W-1:0] exp_data_q [$];
	axi_resp_e             exp_resp_q [$];
	logic [AXI_ID_W-1:0]   exp_id_q   [$];
	bit                    exp_last_q [$];

	logic [AXI_ADDR_W-1:0] r_addr [N_RAND];
	logic [AXI_LEN_W-1:0]  r_len  [N_RAND];
	acc_size_e             r_size [N_RAND];

	int errors        = 0;
	int beats_checked = 0;
	int cycles        = 0;
	int cycle_limit   = 0;

	axi_read_top u_dut (.*);

	always #2 clk = ~clk;

	// Lane of 1, 2, 4 or 8 bytes from the offset, moved to byte 0
	function automatic logic [AXI_DATA_W-1:0] exp_beat(input logic [AXI_DATA_W-1:0] word,
			input logic [2:0] offset, input acc_size_e size);
		logic [AXI_DATA_W-1:0] lane;
		int                    nbytes;
		lane   = '0;
		nbytes = 1 << int'(size);
		for (int i = 0; i < nbytes; i++) begin
			if (int'(offset) + i < 8) begin
				lane[8*i +: 8] = word[8*(int'(offset) + i) +: 8];
			end
		end
		return lane;
	endfunction

	task automatic check_data(input string name, input logic [AXI_DATA_W-1:0] exp,
			input logic [AXI_DATA_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s data expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s resp expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_id(input string name, input logic [AXI_ID_W-1:0] exp,
			input logic [AXI_ID_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s id expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_last(input string name, input bit exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s flag expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("Fail %s latency expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic step();
		@(posedge clk);
		#0.5;
	endtask

	task automatic cfg_write(input cfg_reg_e sel, input logic [CFG_DATA_W-1:0] value);
		cfg_we_i    = 1'b1;
		cfg_sel_i   = sel;
		cfg_wdata_i = value;
		if (sel == CFG_ERR_BASE) begin
			err_base_m = value;
		end
		step();
		cfg_we_i = 1'b0;
	endtask

	// Waits for ready, holds the request one edge, queues its beats
	task automatic issue_read(input string name, input logic [AXI_ID_W-1:0] id,
			input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_LEN_W-1:0] len,
			input acc_size_e size);
		logic [AXI_ADDR_W-1:0] baddr;
		logic [MEM_IDX_W-1:0]  widx;
		while (!cpu_ar_ready_o) begin
			step();
		end
		cpu_ar_valid_i = 1'b1;
		cpu_id_i       = id;
		cpu_addr_i     = addr;
		cpu_len_i      = len;
		cpu_size_i     = size;
		for (int b = 0; b <= int'(len); b++) begin
			baddr = {addr[AXI_ADDR_W-1:3], 3'b000} + AXI_ADDR_W'(8 * b);
			widx  = MEM_IDX_W'(baddr >> 3); // Wraps at MEM_WORDS
			exp_name_q.push_back(name);
			exp_id_q.push_back(id);
			exp_last_q.push_back(b == int'(len));
			if (baddr >= err_base_m) begin
				exp_data_q.push_back('0);
				exp_resp_q.push_back(RESP_SLVERR);
			end else begin
				exp_data_q.push_back(exp_beat(mem_model[widx], addr[2:0], size));
				exp_resp_q.push_back(RESP_OKAY);
			end
		end
		step();
		cpu_ar_valid_i = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_data_q.size() != 0) begin
			step();
		end
	endtask

	task automatic report_and_finish();
		errors += int'(u_dut.u_master.u_props.fail_cnt);
		$display("Errors: %0d, beats checked: %0d, cycles: %0d", errors, beats_checked, cycles);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (reset_n === 1'b1 && cpu_r_valid_o === 1'b1) begin
			if (exp_data_q.size() == 0) begin
				errors++;
				$display("DUT returned a beat while no read was outstanding");
			end else begin
				check_data(exp_name_q[0], exp_data_q.pop_front(), cpu_r_data_o);
				check_resp(exp_name_q[0], exp_resp_q.pop_front(), cpu_r_resp_o);
				check_id(exp_name_q[0], exp_id_q.pop_front(), cpu_r_id_o);
				check_last(exp_name_q[0], exp_last_q.pop_front(), cpu_r_last_o);
				exp_name_q.delete(0);
				beats_checked++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			errors++;
			$display("Timeout after %0d cycles, the DUT stopped answering", cycles);
			report_and_finish();
		end
	end

	initial begin
		int total;
		int lat;
		void'($urandom(32'h4aad_e490));
		reset_n        = 1'b0;
		cpu_ar_valid_i = 1'b0;
		cpu_id_i       = '0;
		cpu_addr_i     = '0;
		cpu_len_i      = '0;
		cpu_size_i     = SIZE_B1;
		cfg_we_i       = 1'b0;
		cfg_sel_i      = CFG_WAIT;
		cfg_wdata_i    = '0;
		mem_we_i       = 1'b0;
		mem_idx_i      = '0;
		mem_wdata_i    = '0;
		err_base_m     = '1;

		// Random requests drawn up front so the run limit covers them
		total = DIRECTED_BEATS + DIRECTED_WAITS;
		for (int i = 0; i < N_RAND; i++) begin
			r_size[i] = acc_size_e'($urandom_range(3, 0));
			r_addr[i] = $urandom_range(32'h7ff, 0) & ~((32'd1 << r_size[i]) - 32'd1);
			r_len[i]  = AXI_LEN_W'($urandom_range(7, 0));
			total += int'(r_len[i]) + 1 + RAND_WAIT;
		end
		cycle_limit = 40 * total + 200;

		repeat (8) @(posedge clk);
		#0.5;
		reset_n = 1'b1;
		check_last("after_reset", 1'b0, cpu_ar_ready_o);
		check_last("after_reset", 1'b0, cpu_r_valid_o);

		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_model[i] = {$urandom(), $urandom()};
			mem_we_i     = 1'b1;
			mem_idx_i    = MEM_IDX_W'(i);
			mem_wdata_i  = mem_model[i];
			step();
		end
		mem_we_i = 1'b0;

		for (int s = 0; s < 4; s++) begin
			for (int off = 0; off < 8; off += (1 << s)) begin
				issue_read("single_size", AXI_ID_W'(off), AXI_ADDR_W'(32'h100 + 8 * s + off),
					'0, acc_size_e'(s));
			end
		end
		wait_idle();

		// Last bursts run past the top of memory
		for (int n = 1; n <= 16; n++) begin
			issue_read("incr_burst", AXI_ID_W'(n), AXI_ADDR_W'(32'h400 + 64 * n),
				AXI_LEN_W'(n - 1), SIZE_B8);
		end
		wait_idle();

		for (int w = 0; w < 8; w++) begin
			cfg_write(CFG_WAIT, CFG_DATA_W'(w));
			issue_read("wait_states", AXI_ID_W'(w), AXI_ADDR_W'(32'h600 + 8 * w), 8'd3, SIZE_B8);
			lat = 0;
			while (!cpu_r_valid_o) begin
				step();
				lat++;
			end
			check_count("wait_states", 2 + w, lat); // AR, waits, beat, CPU pulse
			wait_idle();
		end
		cfg_write(CFG_WAIT, '0);

		cfg_write(CFG_ERR_BASE, 32'h0000_0340);
		issue_read("err_boundary", 4'ha, 32'h0000_0320, 8'd7, SIZE_B8);
		wait_idle();

		cfg_write(CFG_WAIT, CFG_DATA_W'(RAND_WAIT));
		cfg_write(CFG_ERR_BASE, 32'h0000_0600);
		for (int i = 0; i < N_RAND; i++) begin
			issue_read("random", AXI_ID_W'(i), r_addr[i], r_len[i], r_size[i]);
		end
		wait_idle();

		repeat (4) step();
		if (exp_data_q.size() != 0) begin
			errors++;
			$display("%0d expected beats never arrived", exp_data_q.size());
		end
		report_and_finish();
	end

endmodule

// ==== tb/axi_read_props.sv ====
`timescale 1ns/1ps

module axi_read_props import axi_pkg::*; (
	input logic                  clk,
	input logic                  reset_n,
	input logic                  ar_valid_i,
	input logic                  ar_ready_i,
	input logic [AXI_ID_W-1:0]   ar_id_i,
	input logic [AXI_ADDR_W-1:0] ar_addr_i,
	input logic [AXI_LEN_W-1:0]  ar_len_i,
	input logic [2:0]            ar_size_i,
	input logic                  cpu_r_valid_i,
	input logic                  cpu_r_last_i,
	input logic                  cpu_ar_ready_i,
	input rd_state_e             state_i
);

	int unsigned fail_cnt = 0; // Failures seen so far

	// AR held with a stable payload until the slave takes it
	ar_stable: assert property (@(posedge clk) disable iff (!reset_n)
		ar_valid_i && !ar_ready_i |=>
			ar_valid_i && $stable({ar_id_i, ar_addr_i, ar_len_i, ar_size_i}))
	else begin
		$error("AR valid or payload changed before the slave accepted it");
		fail_cnt++;
	end

	// Valid pulse ends with the last beat
	r_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_r_valid_i && cpu_r_last_i |=> !cpu_r_valid_i)
	else begin
		$error("CPU data valid stayed high after the last beat of a read");
		fail_cnt++;
	end

	busy_no_ready: assert property (@(posedge clk) disable iff (!reset_n)
		state_i != RD_IDLE |-> !cpu_ar_ready_i)
	else begin
		$error("CPU request ready is high while a read is open");
		fail_cnt++;
	end

endmodule

bind axi_read_master axi_read_props u_props (
	.clk            (clk),
	.reset_n        (reset_n),
	.ar_valid_i     (axi_ar_valid_o),
	.ar_ready_i     (axi_ar_ready_i),
	.ar_id_i        (axi_ar_id_o),
	.ar_addr_i      (axi_ar_addr_o),
	.ar_len_i       (axi_ar_len_o),
	.ar_size_i      (axi_ar_size_o),
	.cpu_r_valid_i  (cpu_r_valid_o),
	.cpu_r_last_i   (cpu_r_last_o),
	.cpu_ar_ready_i (cpu_ar_ready_o),
	.state_i        (state_q)
);

// ==== logic/axi_read_top.sv ====
`timescale 1ns/1ps

module axi_read_top import axi_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_n,

	input  logic                  cpu_ar_valid_i,
	input  logic [AXI_ID_W-1:0]   cpu_id_i,
	input  logic [AXI_ADDR_W-1:0] cpu_addr_i,
	input  logic [AXI_LEN_W-1:0]  cpu_len_i,
	input  acc_size_e             cpu_size_i,
	output logic                  cpu_ar_ready_o,
	output logic                  cpu_r_valid_o,
	output logic [AXI_DATA_W-1:0] cpu_r_data_o,
	output axi_resp_e             cpu_r_resp_o,
	output logic [AXI_ID_W-1:0]   cpu_r_id_o,
	output logic                  cpu_r_last_o,

	input  logic                  cfg_we_i,
	input  cfg_reg_e              cfg_sel_i,
	input  logic [CFG_DATA_W-1:0] cfg_wdata_i,

	input  logic                  mem_we_i,
	input  logic [MEM_IDX_W-1:0]  mem_idx_i,
	input  logic [AXI_DATA_W-1:0] mem_wdata_i
);

	// AR channel
	logic                  ar_valid;
	logic                  ar_ready;
	logic [AXI_ID_W-1:0]   ar_id;
	logic [AXI_ADDR_W-1:0] ar_addr;
	logic [AXI_LEN_W-1:0]  ar_len;
	logic [2:0]            ar_size;

	// R channel
	logic                  r_valid;
	logic                  r_ready;
	logic [AXI_DATA_W-1:0] r_data;
	axi_resp_e             r_resp;
	logic [AXI_ID_W-1:0]   r_id;
	logic                  r_last;

	logic [CFG_DATA_W-1:0] wait_cycles;
	logic [CFG_DATA_W-1:0] err_base;

	axi_read_master u_master (
		.clk            (clk),
		.reset_n        (reset_n),
		.cpu_ar_valid_i (cpu_ar_valid_i),
		.cpu_id_i       (cpu_id_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_len_i      (cpu_len_i),
		.cpu_size_i     (cpu_size_i),
		.cpu_ar_ready_o (cpu_ar_ready_o),
		.cpu_r_valid_o  (cpu_r_valid_o),
		.cpu_r_data_o   (cpu_r_data_o),
		.cpu_r_resp_o   (cpu_r_resp_o),
		.cpu_r_id_o     (cpu_r_id_o),
		.cpu_r_last_o   (cpu_r_last_o),
		.axi_ar_valid_o (ar_valid),
		.axi_ar_id_o    (ar_id),
		.axi_ar_addr_o  (ar_addr),
		.axi_ar_len_o   (ar_len),
		.axi_ar_size_o  (ar_size),
		.axi_ar_ready_i (ar_ready),
		.axi_r_ready_o  (r_ready),
		.axi_r_valid_i  (r_valid),
		.axi_r_data_i   (r_data),
		.axi_r_resp_i   (r_resp),
		.axi_r_id_i     (r_id),
		.axi_r_last_i   (r_last)
	);

	mem_read_slave u_slave (
		.clk           (clk),
		.reset_n       (reset_n),
		.ar_valid_i    (ar_valid),
		.ar_id_i       (ar_id),
		.ar_addr_i     (ar_addr),
		.ar_len_i      (ar_len),
		.ar_size_i     (ar_size),
		.ar_ready_o    (ar_ready),
		.r_ready_i     (r_ready),
		.r_valid_o     (r_valid),
		.r_data_o      (r_data),
		.r_resp_o      (r_resp),
		.r_id_o        (r_id),
		.r_last_o      (r_last),
		.wait_cycles_i (wait_cycles),
		.err_base_i    (err_base),
		.mem_we_i      (mem_we_i),
		.mem_idx_i     (mem_idx_i),
		.mem_wdata_i   (mem_wdata_i)
	);

	slave_cfg_regs u_cfg (
		.clk           (clk),
		.reset_n       (reset_n),
		.cfg_we_i      (cfg_we_i),
		.cfg_sel_i     (cfg_sel_i),
		.cfg_wdata_i   (cfg_wdata_i),
		.wait_cycles_o (wait_cycles),
		.err_base_o    (err_base)
	);

endmodule

// ==== logic/slave_cfg_regs.sv ====
`timescale 1ns/1ps

module slave_cfg_regs import axi_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  cfg_we_i,
	input  cfg_reg_e              cfg_sel_i,
	input  logic [CFG_DATA_W-1:0] cfg_wdata_i,
	output logic [CFG_DATA_W-1:0] wait_cycles_o,
	output logic [CFG_DATA_W-1:0] err_base_o
);

	logic [CFG_DATA_W-1:0] wait_q;
	logic [CFG_DATA_W-1:0] err_base_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wait_q     <= '0;
			err_base_q <= '1; // No error region by default
		end else if (cfg_we_i) begin
			case (cfg_sel_i)
				CFG_WAIT:     wait_q     <= cfg_wdata_i;
				CFG_ERR_BASE: err_base_q <= cfg_wdata_i;
				default: begin
					wait_q     <= wait_q;
					err_base_q <= err_base_q;
				end
			endcase
		end
	end

	assign wait_cycles_o = wait_q;
	assign err_base_o    = err_base_q;

endmodule

// ==== logic/mem_read_slave.sv ====
`timescale 1ns/1ps

module mem_read_slave import axi_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_n,

	input  logic                  ar_valid_i,
	input  logic [AXI_ID_W-1:0]   ar_id_i,
	input  logic [AXI_ADDR_W-1:0] ar_addr_i,
	input  logic [AXI_LEN_W-1:0]  ar_len_i,
	input  logic [2:0]            ar_size_i,
	output logic                  ar_ready_o,

	input  logic                  r_ready_i,
	output logic                  r_valid_o,
	output logic [AXI_DATA_W-1:0] r_data_o,
	output axi_resp_e             r_resp_o,
	output logic [AXI_ID_W-1:0]   r_id_o,
	output logic                  r_last_o,

	input  logic [CFG_DATA_W-1:0] wait_cycles_i,
	input  logic [CFG_DATA_W-1:0] err_base_i,

	input  logic                  mem_we_i,
	input  logic [MEM_IDX_W-1:0]  mem_idx_i,
	input  logic [AXI_DATA_W-1:0] mem_wdata_i
);

	logic [AXI_DATA_W-1:0] mem [MEM_WORDS];

	slv_state_e state_q;

	logic [CFG_DATA_W-1:0] wait_cnt_q;
	logic [AXI_LEN_W-1:0]  beats_left_q;
	logic [AXI_ADDR_W-1:0] beat_addr_q;
	logic [CFG_DATA_W-1:0] err_base_q;
	logic [AXI_ID_W-1:0]   id_q;
	logic                  size_bad_q;

	logic                  ar_hs;
	logic                  r_hs;
	logic [MEM_IDX_W-1:0]  word_idx;
	logic                  beat_err;

	assign ar_hs = ar_valid_i & ar_ready_o;
	assign r_hs  = r_valid_o & r_ready_i;

	always_ff @(posedge clk) begin
		if (mem_we_i) begin
			mem[mem_idx_i] <= mem_wdata_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q      <= SLV_IDLE;
			wait_cnt_q   <= '0;
			beats_left_q <= '0;
		end else begin
			case (state_q)
				SLV_IDLE: begin
					if (ar_hs) begin
						state_q      <= (wait_cycles_i == '0) ? SLV_BEAT : SLV_WAIT;
						wait_cnt_q   <= wait_cycles_i - CFG_DATA_W'(1);
						beats_left_q <= ar_len_i;
					end
				end
				SLV_WAIT: begin
					if (wait_cnt_q == '0) begin
						state_q <= SLV_BEAT;
					end else begin
						wait_cnt_q <= wait_cnt_q - CFG_DATA_W'(1);
					end
				end
				SLV_BEAT: begin
					if (r_hs) begin
						if (beats_left_q == '0) begin
							state_q <= SLV_IDLE;
						end else begin
							beats_left_q <= beats_left_q - AXI_LEN_W'(1);
						end
					end
				end
				default: state_q <= SLV_IDLE;
			endcase
		end
	end

	// Burst context sampled at AR, so config changes wait for the next AR
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			id_q        <= ar_id_i;
			beat_addr_q <= {ar_addr_i[AXI_ADDR_W-1:3], 3'b000};
			err_base_q  <= err_base_i;
			size_bad_q  <= (ar_size_i > 3'd3); // Wider than the 8-byte bus
		end else if (r_hs) begin
			beat_addr_q <= beat_addr_q + AXI_ADDR_W'(8); // INCR, one word per beat
		end
	end

	// Index wraps at MEM_WORDS
	assign word_idx = beat_addr_q[MEM_IDX_W+2:3];
	assign beat_err = size_bad_q | (beat_addr_q >= err_base_q);

	assign ar_ready_o = (state_q == SLV_IDLE);
	assign r_valid_o  = (state_q == SLV_BEAT);
	assign r_data_o   = beat_err ? '0 : mem[word_idx];
	assign r_resp_o   = beat_err ? RESP_SLVERR : RESP_OKAY;
	assign r_id_o     = id_q;
	assign r_last_o   = (beats_left_q == '0);

endmodule

// ==== logic/axi_read_master.sv ====
`timescale 1ns/1ps

module axi_read_master import axi_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_n,

	input  logic                  cpu_ar_valid_i,
	input  logic [AXI_ID_W-1:0]   cpu_id_i,
	input  logic [AXI_ADDR_W-1:0] cpu_addr_i,
	input  logic [AXI_LEN_W-1:0]  cpu_len_i,
	input  acc_size_e             cpu_size_i,
	output logic                  cpu_ar_ready_o,
	output logic                  cpu_r_valid_o,
	output logic [AXI_DATA_W-1:0] cpu_r_data_o,
	output axi_resp_e             cpu_r_resp_o,
	output logic [AXI_ID_W-1:0]   cpu_r_id_o,
	output logic                  cpu_r_last_o,

	output logic                  axi_ar_valid_o,
	output logic [AXI_ID_W-1:0]   axi_ar_id_o,
	output logic [AXI_ADDR_W-1:0] axi_ar_addr_o,
	output logic [AXI_LEN_W-1:0]  axi_ar_len_o,
	output logic [2:0]            axi_ar_size_o,
	input  logic                  axi_ar_ready_i,

	output logic                  axi_r_ready_o,
	input  logic                  axi_r_valid_i,
	input  logic [AXI_DATA_W-1:0] axi_r_data_i,
	input  axi_resp_e             axi_r_resp_i,
	input  logic [AXI_ID_W-1:0]   axi_r_id_i,
	input  logic                  axi_r_last_i
);

	rd_state_e state_q;
	rd_state_e state_d;

	logic                  ar_ready_q;
	logic                  cpu_accept;
	logic                  ar_hs;
	logic                  r_hs;
	logic                  r_done;

	logic [AXI_ID_W-1:0]   id_q;
	logic [AXI_ADDR_W-1:0] addr_q;
	logic [AXI_LEN_W-1:0]  len_q;
	acc_size_e             size_q;

	logic [AXI_DATA_W-1:0] aligned_data;

	assign cpu_accept = cpu_ar_valid_i & ar_ready_q;
	assign ar_hs      = axi_ar_valid_o & axi_ar_ready_i;
	assign r_hs       = axi_r_valid_i & axi_r_ready_o;
	assign r_done     = r_hs & axi_r_last_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			RD_IDLE: begin
				if (cpu_accept) begin
					state_d = RD_ADDR;
				end
			end
			RD_ADDR: begin
				if (ar_hs) begin
					state_d = RD_DATA;
				end
			end
			RD_DATA: begin
				if (r_done) begin
					state_d = RD_IDLE;
				end
			end
			default: state_d = RD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q    <= RD_IDLE;
			ar_ready_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Ready drops on acceptance, back after the last beat
			if (cpu_accept) begin
				ar_ready_q <= 1'b0;
			end else if (state_q == RD_IDLE || r_done) begin
				ar_ready_q <= 1'b1;
			end
		end
	end

	// Request held for the whole burst
	always_ff @(posedge clk) begin
		if (cpu_accept) begin
			id_q   <= cpu_id_i;
			addr_q <= cpu_addr_i;
			len_q  <= cpu_len_i;
			size_q <= cpu_size_i;
		end
	end

	assign cpu_ar_ready_o = ar_ready_q;

	assign axi_ar_valid_o = (state_q == RD_ADDR);
	assign axi_ar_id_o    = id_q;
	assign axi_ar_addr_o  = {addr_q[AXI_ADDR_W-1:3], 3'b000}; // Bus aligned
	assign axi_ar_len_o   = len_q;
	assign axi_ar_size_o  = {1'b0, size_q};

	assign axi_r_ready_o = (state_q == RD_DATA);

	read_align u_align (
		.beat_i   (axi_r_data_i),
		.offset_i (addr_q[2:0]),
		.size_i   (size_q),
		.data_o   (aligned_data)
	);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cpu_r_valid_o <= 1'b0;
		end else begin
			cpu_r_valid_o <= r_hs; // One pulse per beat
		end
	end

	always_ff @(posedge clk) begin
		if (r_hs) begin
			cpu_r_data_o <= aligned_data;
			cpu_r_resp_o <= axi_r_resp_i;
			cpu_r_id_o   <= axi_r_id_i;
			cpu_r_last_o <= axi_r_last_i;
		end
	end

endmodule

// ==== logic/read_align.sv ====
`timescale 1ns/1ps

module read_align import axi_pkg::*; (
	input  logic [AXI_DATA_W-1:0] beat_i,
	input  logic [2:0]            offset_i,
	input  acc_size_e             size_i,
	output logic [AXI_DATA_W-1:0] data_o
);

	logic [5:0]            shift_bits;
	logic [AXI_DATA_W-1:0] shifted;
	logic [AXI_DATA_W-1:0] lane_mask;

	assign shift_bits = {offset_i, 3'b000}; // Byte offset in bits
	assign shifted    = beat_i >> shift_bits;

	always_comb begin
		case (size_i)
			SIZE_B1: lane_mask = {{(AXI_DATA_W-8){1'b0}}, 8'hff};
			SIZE_B2: lane_mask = {{(AXI_DATA_W-16){1'b0}}, 16'hffff};
			SIZE_B4: lane_mask = {{(AXI_DATA_W-32){1'b0}}, 32'hffff_ffff};
			SIZE_B8: lane_mask = {AXI_DATA_W{1'b1}};
			default: lane_mask = {AXI_DATA_W{1'b1}};
		endcase
	end

	// Lane now sits at bit 0, upper bytes cleared
	assign data_o = shifted & lane_mask;

endmodule

// ==== logic/axi_pkg.sv ====
package axi_pkg;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 64;
	localparam int AXI_ID_W   = 4;
	localparam int AXI_LEN_W  = 8;

	localparam int MEM_WORDS = 256; // 64-bit words
	localparam int MEM_IDX_W = 8;

	localparam int CFG_DATA_W = 32;

	// CPU access size, also the low bits of ARSIZE
	typedef enum logic [1:0] {
		SIZE_B1 = 2'd0,
		SIZE_B2 = 2'd1,
		SIZE_B4 = 2'd2,
		SIZE_B8 = 2'd3
	} acc_size_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	typedef enum logic [1:0] {
		RD_IDLE = 2'd0,
		RD_ADDR = 2'd1,
		RD_DATA = 2'd2
	} rd_state_e;

	typedef enum logic [1:0] {
		SLV_IDLE = 2'd0,
		SLV_WAIT = 2'd1,
		SLV_BEAT = 2'd2
	} slv_state_e;

	typedef enum logic {
		CFG_WAIT     = 1'b0,
		CFG_ERR_BASE = 1'b1
	} cfg_reg_e;

endpackage
